// ==== rv_core.f ====
src/isa_pkg.sv
src/axi_pkg.sv
src/fetch_unit.sv
src/decoder.sv
src/execute_unit.sv
src/load_store_unit.sv
src/register_file.sv
src/bus_arbiter.sv
src/rv_core.sv
testbench/axi_memory_model.sv
testbench/tb_rv_core.sv

// ==== testbench/tb_rv_core.sv ====
`timescale 1ns/100ps

module tb_rv_core;

	localparam logic [31:0] RESET_PC = 32'h3000_0000;
	localparam logic [31:0] DATA = RESET_PC + 32'h800;
	localparam logic [31:0] POISON_ADDR = DATA + 32'h40;
	localparam int PROG_LEN = 28;
	localparam int CLK_PERIOD = 100;
	localparam int N_STORES = 9;
	localparam int DONE_IDX = 8;

	logic         clock;
	logic         rst_n;
	axi_pkg::ar_t ar;
	logic         ar_valid;
	logic         ar_ready;
	axi_pkg::r_t  r;
	logic         r_valid;
	logic         r_ready;
	axi_pkg::aw_t aw;
	logic         aw_valid;
	logic         aw_ready;
	axi_pkg::w_t  w;
	logic         w_valid;
	logic         w_ready;
	axi_pkg::b_t  b;
	logic         b_valid;
	logic         b_ready;
	int           proto_errors;

	logic [31:0] prog [PROG_LEN];
	logic [31:0] exp_addr [N_STORES];
	logic [31:0] exp_data [N_STORES];
	int          exp_test [N_STORES];
	bit          seen [N_STORES];
	// instruction indices in fetch order, the final jal loops on index 27
	int          exp_fetch [$] = '{0, 1, 2, 3, 4, 5, 6, 7, 8, 9, 10, 11, 12, 13, 14, 16, 17,
		18, 20, 21, 22, 24, 25, 26, 27};
	int          test_errs [1:6];
	bit          reported [1:6];
	int          fail_count = 0;
	int          pass_count = 0;
	int          fetch_n = 0;
	bit          first_ar_seen = 0;
	bit          done_seen = 0;
	bit          started = 0;
	bit          aw_got = 0;
	bit          w_got = 0;
	logic [31:0] st_addr;
	logic [31:0] st_data;

	rv_core #(.RESET_PC(RESET_PC), .REG_COUNT(16)) u_rv_core (.*);

	axi_memory_model #(.BASE(RESET_PC), .WORDS(1024)) u_memory (.*);

	function automatic logic [31:0] u_type(logic [6:0] opc, logic [4:0] rd, logic [19:0] imm);
		return {imm, rd, opc};
	endfunction

	function automatic logic [31:0] i_type(logic [6:0] opc, logic [4:0] rd, logic [4:0] rs1,
		logic [11:0] imm, logic [2:0] f3);
		return {imm, rs1, f3, rd, opc};
	endfunction

	function automatic logic [31:0] r_add(logic [4:0] rd, logic [4:0] rs1, logic [4:0] rs2);
		return {7'b0, rs2, rs1, 3'b000, rd, 7'b0110011};
	endfunction

	function automatic logic [31:0] s_word(logic [4:0] rs2, logic [4:0] rs1, logic [11:0] imm);
		return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] b_eq(logic [4:0] rs1, logic [4:0] rs2, logic [12:0] imm);
		return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] j_link(logic [4:0] rd, logic [20:0] imm);
		return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
	endfunction

	task automatic load_program();
		prog[0] = u_type(7'b0110111, 1, 20'h30001);                  // x1 = 3000_1000
		prog[1] = i_type(7'b0010011, 1, 1, 12'h800, 3'b000);        // x1 = 3000_0800
		prog[2] = s_word(1, 1, 12'h000);
		prog[3] = u_type(7'b0010111, 2, 20'h00001);
		prog[4] = s_word(2, 1, 12'h004);
		prog[5] = i_type(7'b0010011, 3, 0, 12'd100, 3'b000);
		prog[6] = i_type(7'b0010011, 4, 0, 12'hff9, 3'b000);        // -7
		prog[7] = r_add(5, 3, 4);
		prog[8] = s_word(5, 1, 12'h008);
		prog[9] = i_type(7'b0000011, 6, 1, 12'h008, 3'b010);
		prog[10] = i_type(7'b0010011, 7, 6, 12'd20, 3'b000);
		prog[11] = s_word(7, 1, 12'h00c);
		prog[12] = i_type(7'b0010011, 0, 0, 12'd55, 3'b000);
		prog[13] = s_word(0, 1, 12'h010);
		prog[14] = b_eq(3, 3, 13'd8);
		prog[15] = s_word(1, 1, 12'h040);
		prog[16] = b_eq(3, 4, 13'd8);
		prog[17] = s_word(3, 1, 12'h014);
		prog[18] = j_link(8, 21'd8);
		prog[19] = s_word(1, 1, 12'h040);
		prog[20] = s_word(8, 1, 12'h018);
		prog[21] = u_type(7'b0010111, 9, 20'h0);
		prog[22] = i_type(7'b1100111, 10, 9, 12'd12, 3'b000);
		prog[23] = s_word(1, 1, 12'h040);
		prog[24] = s_word(10, 1, 12'h01c);
		prog[25] = i_type(7'b0010011, 11, 0, 12'd1, 3'b000);
		prog[26] = s_word(11, 1, 12'h03c);
		prog[27] = j_link(0, 21'd0);
		for (int i = 0; i < PROG_LEN; i++)
			u_memory.mem[i] = prog[i];
	endtask

	task automatic set_expected(int i, logic [31:0] offs, logic [31:0] data, int t);
		exp_addr[i] = DATA + offs;
		exp_data[i] = data;
		exp_test[i] = t;
		seen[i] = 0;
	endtask

	task automatic load_expected();
		set_expected(0, 32'h00, 32'h3000_0800, 2);
		set_expected(1, 32'h04, 32'h3000_100c, 2); // auipc at 3000_000c
		set_expected(2, 32'h08, 32'd93, 2);
		set_expected(3, 32'h0c, 32'd113, 3);
		set_expected(4, 32'h10, 32'd0, 5);
		set_expected(5, 32'h14, 32'd100, 4);
		set_expected(6, 32'h18, 32'h3000_004c, 4);
		set_expected(7, 32'h1c, 32'h3000_005c, 4);
		set_expected(DONE_IDX, 32'h3c, 32'd1, 6);
	endtask

	task automatic value_fail(int t, string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		fail_count++;
		test_errs[t]++;
	endtask

	task automatic report_test(int t);
		string name;
		case (t)
			1: name = "reset and first fetch";
			2: name = "arithmetic";
			3: name = "load after store";
			4: name = "control flow";
			5: name = "zero register";
			default: name = "bus protocol";
		endcase
		reported[t] = 1;
		if (test_errs[t] == 0) begin
			pass_count++;
			$display("test %0d %s: pass", t, name);
		end else begin
			$display("test %0d %s: FAIL with %0d errors", t, name, test_errs[t]);
		end
	endtask

	function automatic bit test_finished(int t);
		for (int i = 0; i < N_STORES; i++)
			if (exp_test[i] == t && !seen[i])
				return 0;
		return 1;
	endfunction

	task automatic check_store(logic [31:0] addr, logic [31:0] data);
		int idx;
		idx = -1;
		for (int i = 0; i < N_STORES; i++)
			if (exp_addr[i] == addr)
				idx = i;
		assert (addr != POISON_ADDR)
			else value_fail(4, "skipped instruction stored to the poison address");
		if (addr == POISON_ADDR)
			return;
		assert (idx >= 0)
			else value_fail(6, $sformatf("store to unexpected address %h", addr));
		if (idx < 0)
			return;
		assert (data == exp_data[idx])
			else value_fail(exp_test[idx], $sformatf("store to %h wrote %h, expected %h",
				addr, data, exp_data[idx]));
		seen[idx] = 1;
		if (idx == DONE_IDX)
			done_seen = 1;
		else if (!reported[exp_test[idx]] && test_finished(exp_test[idx]))
			report_test(exp_test[idx]);
	endtask

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock)
		started <= 1'b1;

	a_quiet_reset: assert property (@(posedge clock) started && !rst_n |-> !ar_valid && !aw_valid)
		else value_fail(1, "ar_valid or aw_valid high during reset");

	// bus monitor on the core's master port
	always @(posedge clock) begin
		if (rst_n && ar_valid && ar_ready) begin
			if (!first_ar_seen) begin
				first_ar_seen = 1;
				assert (ar.addr == RESET_PC && ar.id == axi_pkg::ID_FETCH)
					else value_fail(1, $sformatf("first ar is %h id %0d", ar.addr, ar.id));
				report_test(1);
			end
			if (ar.id == axi_pkg::ID_FETCH) begin
				assert (ar.addr == RESET_PC
					+ 4 * (fetch_n < exp_fetch.size() ? exp_fetch[fetch_n] : 27))
					else value_fail(4, $sformatf("fetch %0d from wrong address %h", fetch_n,
						ar.addr));
				fetch_n++;
			end
		end
		if (rst_n && aw_valid && aw_ready) begin
			st_addr = aw.addr;
			aw_got = 1;
		end
		if (rst_n && w_valid && w_ready) begin
			st_data = w.data;
			w_got = 1;
		end
		if (aw_got && w_got) begin
			aw_got = 0;
			w_got = 0;
			check_store(st_addr, st_data);
		end
	end

	initial begin
		#(PROG_LEN * 40 * CLK_PERIOD);
		$display("watchdog expired before the program reached its done store");
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		for (int t = 1; t <= 6; t++) begin
			test_errs[t] = 0;
			reported[t] = 0;
		end
		load_expected();
		@(posedge clock);
		load_program();
		repeat (3) @(posedge clock);
		rst_n <= 1'b1;
		wait (done_seen && fetch_n >= exp_fetch.size() + 2); // the end loop has turned twice
		@(posedge clock);
		for (int i = 0; i < N_STORES; i++) begin
			if (!seen[i]) begin
				$display("expected store to %h never happened", exp_addr[i]);
				fail_count++;
				test_errs[exp_test[i]]++;
			end
		end
		fail_count += proto_errors;
		test_errs[6] += proto_errors;
		for (int t = 1; t <= 6; t++)
			if (!reported[t])
				report_test(t);
		$display("tests run: 6, passed: %0d, checks failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

// ==== testbench/axi_memory_model.sv ====
`timescale 1ns/100ps

module axi_memory_model #(
	parameter logic [31:0] BASE  = 32'h3000_0000,
	parameter int          WORDS = 1024
) (
	input  logic         clock,
	input  logic         rst_n,
	input  axi_pkg::ar_t ar,
	input  logic         ar_valid,
	output logic         ar_ready,
	output axi_pkg::r_t  r,
	output logic         r_valid,
	input  logic         r_ready,
	input  axi_pkg::aw_t aw,
	input  logic         aw_valid,
	output logic         aw_ready,
	input  axi_pkg::w_t  w,
	input  logic         w_valid,
	output logic         w_ready,
	output axi_pkg::b_t  b,
	output logic         b_valid,
	input  logic         b_ready,
	output int           proto_errors
);

	logic [31:0] mem [WORDS];
	logic [31:0] rng;
	logic [1:0]  ar_wait;
	logic [1:0]  r_wait;
	logic [1:0]  aw_wait;
	logic [1:0]  w_wait;
	logic [1:0]  b_wait;
	logic        rd_busy;
	logic [31:0] rd_addr;
	logic [3:0]  rd_id;
	logic        aw_got;
	logic        w_got;
	logic [31:0] wr_addr;
	logic [31:0] wr_data;

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] s;
		s = x ^ (x << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	function automatic int word_index(input logic [31:0] addr);
		return int'(((addr - BASE) >> 2) % WORDS);
	endfunction

	initial begin
		for (int i = 0; i < WORDS; i++)
			mem[i] = '0;
		rng = 32'h6408_2789;
		{ar_ready, r_valid, aw_ready, w_ready, b_valid} = '0;
		r = '0;
		b = '0;
		{ar_wait, r_wait, aw_wait, w_wait, b_wait} = '0;
		{rd_busy, aw_got, w_got} = '0;
		proto_errors = 0;
	end

	always @(posedge clock) begin
		rng <= xorshift(rng); // each channel uses its own two bits as a delay of 0 to 3 cycles
		if (!rst_n) begin
			{ar_ready, r_valid, aw_ready, w_ready, b_valid} <= '0;
			{rd_busy, aw_got, w_got} <= '0;
		end else begin
			if (ar_valid && ar_ready) begin
				ar_ready <= 1'b0;
				rd_busy <= 1'b1;
				rd_addr <= ar.addr;
				rd_id <= ar.id;
				ar_wait <= rng[1:0];
				r_wait <= rng[3:2];
			end else if (ar_valid && !rd_busy) begin
				if (ar_wait == 0)
					ar_ready <= 1'b1;
				else
					ar_wait <= ar_wait - 1'b1;
			end
			if (r_valid && r_ready) begin
				r_valid <= 1'b0;
				rd_busy <= 1'b0;
			end else if (rd_busy && !r_valid) begin
				if (r_wait == 0) begin
					r_valid <= 1'b1;
					r <= '{data: mem[word_index(rd_addr)], resp: 2'b00, id: rd_id};
				end else begin
					r_wait <= r_wait - 1'b1;
				end
			end
			if (aw_valid && aw_ready) begin
				aw_ready <= 1'b0;
				aw_got <= 1'b1;
				wr_addr <= aw.addr;
				aw_wait <= rng[5:4];
			end else if (aw_valid && !aw_got) begin
				if (aw_wait == 0)
					aw_ready <= 1'b1;
				else
					aw_wait <= aw_wait - 1'b1;
			end
			if (w_valid && w_ready) begin
				w_ready <= 1'b0;
				w_got <= 1'b1;
				wr_data <= w.data;
				w_wait <= rng[7:6];
				b_wait <= rng[9:8];
			end else if (w_valid && !w_got) begin
				if (w_wait == 0)
					w_ready <= 1'b1;
				else
					w_wait <= w_wait - 1'b1;
			end
			if (b_valid && b_ready) begin
				b_valid <= 1'b0;
			end else if (aw_got && w_got && !b_valid) begin
				if (b_wait == 0) begin
					mem[word_index(wr_addr)] <= wr_data;
					b <= '{resp: 2'b00};
					b_valid <= 1'b1;
					aw_got <= 1'b0;
					w_got <= 1'b0;
				end else begin
					b_wait <= b_wait - 1'b1;
				end
			end
		end
	end

	a_ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && !ar_ready |=> ar_valid && $stable(ar))
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: ar payload changed before its handshake", $time);
		end

	a_aw_stable: assert property (@(posedge clock) disable iff (!rst_n)
		aw_valid && !aw_ready |=> aw_valid && $stable(aw))
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: aw payload changed before its handshake", $time);
		end

	a_w_stable: assert property (@(posedge clock) disable iff (!rst_n)
		w_valid && !w_ready |=> w_valid && $stable(w))
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: w payload changed before its handshake", $time);
		end

	a_full_strobe: assert property (@(posedge clock) disable iff (!rst_n)
		w_valid |-> w.strb == 4'hf)
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: store strobe is %h, not f", $time, w.strb);
		end

	// every access is a single four-byte beat
	a_word_size: assert property (@(posedge clock) disable iff (!rst_n)
		(!ar_valid || ar.size == 3'b010) && (!aw_valid || aw.size == 3'b010))
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: access size is not one word", $time);
		end

	a_one_read: assert property (@(posedge clock) disable iff (!rst_n)
		rd_busy |-> !ar_valid)
		else begin
			proto_errors++;
			$display("CHECK FAILED at %0t: second ar issued before the first r", $time);
		end

endmodule

// ==== src/rv_core.sv ====
`timescale 1ns/100ps

module rv_core #(
	parameter logic [31:0] RESET_PC  = 32'h3000_0000,
	parameter int          REG_COUNT = 16
) (
	input  logic         clock,
	input  logic         rst_n,
	output axi_pkg::ar_t ar,
	output logic         ar_valid,
	input  logic         ar_ready,
	input  axi_pkg::r_t  r,
	input  logic         r_valid,
	output logic         r_ready,
	output axi_pkg::aw_t aw,
	output logic         aw_valid,
	input  logic         aw_ready,
	output axi_pkg::w_t  w,
	output logic         w_valid,
	input  logic         w_ready,
	input  axi_pkg::b_t  b,
	input  logic         b_valid,
	output logic         b_ready
);

	isa_pkg::decoded_t decoded;
	logic [31:0]       inst;
	logic              inst_valid;
	logic              retire;
	logic [31:0]       pc;
	logic [31:0]       next_pc;
	logic [31:0]       mem_addr;
	logic [31:0]       wb_data;
	logic [31:0]       load_data;
	logic              mem_done;
	logic [31:0]       src1;
	logic [31:0]       src2;

	axi_pkg::ar_t fetch_ar;
	logic         fetch_ar_valid;
	logic         fetch_ar_ready;
	axi_pkg::r_t  fetch_r;
	logic         fetch_r_valid;
	logic         fetch_r_ready;
	axi_pkg::ar_t lsu_ar;
	logic         lsu_ar_valid;
	logic         lsu_ar_ready;
	axi_pkg::r_t  lsu_r;
	logic         lsu_r_valid;
	logic         lsu_r_ready;
	axi_pkg::aw_t lsu_aw;
	logic         lsu_aw_valid;
	logic         lsu_aw_ready;
	axi_pkg::w_t  lsu_w;
	logic         lsu_w_valid;
	logic         lsu_w_ready;
	axi_pkg::b_t  lsu_b;
	logic         lsu_b_valid;
	logic         lsu_b_ready;

	fetch_unit #(.RESET_PC(RESET_PC)) u_fetch_unit (.*);

	decoder #(.REG_COUNT(REG_COUNT)) u_decoder (.*);

	execute_unit u_execute_unit (.*);

	// the unit's write channels reach the port through the arbiter
	load_store_unit u_load_store_unit (
		.*,
		.aw(lsu_aw),
		.aw_valid(lsu_aw_valid),
		.aw_ready(lsu_aw_ready),
		.w(lsu_w),
		.w_valid(lsu_w_valid),
		.w_ready(lsu_w_ready),
		.b(lsu_b),
		.b_valid(lsu_b_valid),
		.b_ready(lsu_b_ready)
	);

	register_file #(.REG_COUNT(REG_COUNT)) u_register_file (.*);

	bus_arbiter u_bus_arbiter (.*);

endmodule

// ==== src/bus_arbiter.sv ====
`timescale 1ns/100ps

module bus_arbiter (
	input  logic         clock,
	input  logic         rst_n,
	input  axi_pkg::ar_t fetch_ar,
	input  logic         fetch_ar_valid,
	output logic         fetch_ar_ready,
	output axi_pkg::r_t  fetch_r,
	output logic         fetch_r_valid,
	input  logic         fetch_r_ready,
	input  axi_pkg::ar_t lsu_ar,
	input  logic         lsu_ar_valid,
	output logic         lsu_ar_ready,
	output axi_pkg::r_t  lsu_r,
	output logic         lsu_r_valid,
	input  logic         lsu_r_ready,
	input  axi_pkg::aw_t lsu_aw,
	input  logic         lsu_aw_valid,
	output logic         lsu_aw_ready,
	input  axi_pkg::w_t  lsu_w,
	input  logic         lsu_w_valid,
	output logic         lsu_w_ready,
	output axi_pkg::b_t  lsu_b,
	output logic         lsu_b_valid,
	input  logic         lsu_b_ready,
	output axi_pkg::ar_t ar,
	output logic         ar_valid,
	input  logic         ar_ready,
	input  axi_pkg::r_t  r,
	input  logic         r_valid,
	output logic         r_ready,
	output axi_pkg::aw_t aw,
	output logic         aw_valid,
	input  logic         aw_ready,
	output axi_pkg::w_t  w,
	output logic         w_valid,
	input  logic         w_ready,
	input  axi_pkg::b_t  b,
	input  logic         b_valid,
	output logic         b_ready
);

	typedef enum logic [1:0] {
		G_NONE,
		G_FETCH,
		G_LSU
	} grant_e;

	grant_e grant;
	logic   r_to_lsu;

	// load/store has priority when both ask in the same cycle
	assign ar = lsu_ar_valid ? lsu_ar : fetch_ar;
	assign ar_valid = (grant == G_NONE) && (lsu_ar_valid || fetch_ar_valid);
	assign lsu_ar_ready = (grant == G_NONE) && ar_ready;
	assign fetch_ar_ready = (grant == G_NONE) && !lsu_ar_valid && ar_ready;

	assign r_to_lsu = (r.id == axi_pkg::ID_LSU);
	assign fetch_r = r;
	assign lsu_r = r;
	assign fetch_r_valid = r_valid && (r.id == axi_pkg::ID_FETCH);
	assign lsu_r_valid = r_valid && r_to_lsu;
	assign r_ready = r_to_lsu ? lsu_r_ready : fetch_r_ready;

	// only the load/store unit writes
	assign aw = lsu_aw;
	assign aw_valid = lsu_aw_valid;
	assign lsu_aw_ready = aw_ready;
	assign w = lsu_w;
	assign w_valid = lsu_w_valid;
	assign lsu_w_ready = w_ready;
	assign lsu_b = b;
	assign lsu_b_valid = b_valid;
	assign b_ready = lsu_b_ready;

	always_ff @(posedge clock) begin
		if (!rst_n)
			grant <= G_NONE;
		else if (ar_valid && ar_ready)
			grant <= lsu_ar_valid ? G_LSU : G_FETCH;
		else if (r_valid && r_ready)
			grant <= G_NONE;
	end

	a_one_grant: assert property (@(posedge clock) disable iff (!rst_n)
		ar_valid && ar_ready |=> grant == (($past(ar.id) == axi_pkg::ID_LSU) ? G_LSU : G_FETCH));

	a_r_granted: assert property (@(posedge clock) disable iff (!rst_n)
		r_valid |-> (grant == G_FETCH && r.id == axi_pkg::ID_FETCH)
			|| (grant == G_LSU && r.id == axi_pkg::ID_LSU));

endmodule

// ==== src/register_file.sv ====
`timescale 1ns/100ps

module register_file #(
	parameter int REG_COUNT = 16
) (
	input  logic              clock,
	input  logic              rst_n,
	input  isa_pkg::decoded_t decoded,
	input  logic              retire,
	input  logic [31:0]       wb_data,
	output logic [31:0]       src1,
	output logic [31:0]       src2
);

	logic [31:0] regs [REG_COUNT];

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			for (int i = 0; i < REG_COUNT; i++)
				regs[i] <= '0;
		end else if (retire && decoded.reg_write && decoded.rd != '0) begin
			regs[decoded.rd] <= wb_data;
		end
	end

	assign src1 = (decoded.rs1 == '0) ? '0 : regs[decoded.rs1]; // x0 is hard zero
	assign src2 = (decoded.rs2 == '0) ? '0 : regs[decoded.rs2];

endmodule

// ==== src/load_store_unit.sv ====
`timescale 1ns/100ps

module load_store_unit (
	input  logic              clock,
	input  logic              rst_n,
	input  isa_pkg::decoded_t decoded,
	input  logic              inst_valid,
	input  logic [31:0]       mem_addr,
	input  logic [31:0]       src2,
	output axi_pkg::ar_t      lsu_ar,
	output logic              lsu_ar_valid,
	input  logic              lsu_ar_ready,
	input  axi_pkg::r_t       lsu_r,
	input  logic              lsu_r_valid,
	output logic              lsu_r_ready,
	output axi_pkg::aw_t      aw,
	output logic              aw_valid,
	input  logic              aw_ready,
	output axi_pkg::w_t       w,
	output logic              w_valid,
	input  logic              w_ready,
	input  axi_pkg::b_t       b,
	input  logic              b_valid,
	output logic              b_ready,
	output logic [31:0]       load_data,
	output logic              mem_done
);

	typedef enum logic [1:0] {
		L_IDLE,
		L_READ,
		L_WRITE,
		L_RESP
	} state_e;

	state_e state;
	logic   is_load;
	logic   is_store;
	logic   start;
	logic   aw_pend;
	logic   w_pend;
	logic   resp_done;

	// decoded stays put until the next fetch, so it can steer the whole access
	assign is_load = (decoded.op == isa_pkg::OP_LW);
	assign is_store = (decoded.op == isa_pkg::OP_SW);
	assign start = (state == L_IDLE) && inst_valid && decoded.is_mem;

	assign lsu_ar = '{addr: mem_addr, id: axi_pkg::ID_LSU, size: axi_pkg::SIZE_WORD};
	assign aw = '{addr: mem_addr, size: axi_pkg::SIZE_WORD};
	assign w = '{data: src2, strb: 4'hf};

	assign lsu_ar_valid = (start && is_load) || (state == L_READ);
	assign aw_valid = (start && is_store) || (state == L_WRITE && aw_pend);
	assign w_valid = (start && is_store) || (state == L_WRITE && w_pend);
	assign lsu_r_ready = (state == L_RESP) && is_load;
	assign b_ready = (state == L_RESP) && is_store;
	assign resp_done = (lsu_r_valid && lsu_r_ready) || (b_valid && b_ready);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= L_IDLE;
			aw_pend <= 1'b0;
			w_pend <= 1'b0;
			mem_done <= 1'b0;
		end else begin
			mem_done <= resp_done;
			case (state)
				L_IDLE: begin
					if (start && is_load) begin
						state <= lsu_ar_ready ? L_RESP : L_READ;
					end else if (start) begin
						aw_pend <= !aw_ready;
						w_pend <= !w_ready;
						state <= (aw_ready && w_ready) ? L_RESP : L_WRITE;
					end
				end
				L_READ: begin
					if (lsu_ar_ready)
						state <= L_RESP;
				end
				L_WRITE: begin
					if (aw_ready)
						aw_pend <= 1'b0;
					if (w_ready)
						w_pend <= 1'b0;
					if ((!aw_pend || aw_ready) && (!w_pend || w_ready))
						state <= L_RESP;
				end
				L_RESP: begin
					if (resp_done)
						state <= L_IDLE;
				end
				default: state <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (lsu_r_valid && lsu_r_ready)
			load_data <= lsu_r.data;
	end

	a_store_only: assert property (@(posedge clock) disable iff (!rst_n)
		($rose(aw_valid) || $rose(w_valid)) |-> inst_valid && is_store);

endmodule

// ==== src/execute_unit.sv ====
`timescale 1ns/100ps

module execute_unit (
	input  isa_pkg::decoded_t decoded,
	input  logic [31:0]       pc,
	input  logic [31:0]       src1,
	input  logic [31:0]       src2,
	input  logic [31:0]       load_data,
	output logic [31:0]       next_pc,
	output logic [31:0]       mem_addr,
	output logic [31:0]       wb_data
);

	logic [31:0] pc_plus4;
	logic [31:0] pc_plus_imm;
	logic [31:0] base_plus_imm;
	logic [31:0] alu_result;

	assign pc_plus4 = pc + 32'd4;
	assign pc_plus_imm = pc + decoded.imm;
	assign base_plus_imm = src1 + decoded.imm; // shared by ADDI, JALR and memory address

	always_comb begin
		alu_result = '0;
		next_pc = pc_plus4;
		case (decoded.op)
			isa_pkg::OP_ADD: alu_result = src1 + src2;
			isa_pkg::OP_ADDI: alu_result = base_plus_imm;
			isa_pkg::OP_LUI: alu_result = decoded.imm;
			isa_pkg::OP_AUIPC: alu_result = pc_plus_imm;
			isa_pkg::OP_JAL: begin
				alu_result = pc_plus4;
				next_pc = pc_plus_imm;
			end
			isa_pkg::OP_JALR: begin
				alu_result = pc_plus4;
				next_pc = {base_plus_imm[31:1], 1'b0};
			end
			isa_pkg::OP_BEQ: begin
				if (src1 == src2)
					next_pc = pc_plus_imm;
			end
			default: ;
		endcase
	end

	assign mem_addr = base_plus_imm;
	assign wb_data = (decoded.op == isa_pkg::OP_LW) ? load_data : alu_result;

endmodule

// ==== src/decoder.sv ====
`timescale 1ns/100ps

module decoder #(
	parameter int REG_COUNT = 16
) (
	input  logic [31:0]       inst,
	output isa_pkg::decoded_t decoded
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_b;
	logic [31:0] imm_u;
	logic [31:0] imm_j;

	// indices past the implemented registers fold onto x0
	function automatic isa_pkg::reg_idx_t reg_map(input logic [4:0] field);
		if (field >= REG_COUNT)
			return '0;
		return field[isa_pkg::REG_IDX_W-1:0];
	endfunction

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];

	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
	assign imm_u = {inst[31:12], 12'b0};
	assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

	always_comb begin
		decoded.op = isa_pkg::OP_NOP;
		decoded.rd = reg_map(inst[11:7]);
		decoded.rs1 = reg_map(inst[19:15]);
		decoded.rs2 = reg_map(inst[24:20]);
		decoded.imm = '0;
		case (opcode)
			isa_pkg::OPC_LUI: begin
				decoded.op = isa_pkg::OP_LUI;
				decoded.imm = imm_u;
			end
			isa_pkg::OPC_AUIPC: begin
				decoded.op = isa_pkg::OP_AUIPC;
				decoded.imm = imm_u;
			end
			isa_pkg::OPC_JAL: begin
				decoded.op = isa_pkg::OP_JAL;
				decoded.imm = imm_j;
			end
			isa_pkg::OPC_JALR: begin
				decoded.op = isa_pkg::OP_JALR;
				decoded.imm = imm_i;
			end
			isa_pkg::OPC_BRANCH: begin
				if (funct3 == 3'b000) begin
					decoded.op = isa_pkg::OP_BEQ;
					decoded.imm = imm_b;
				end
			end
			isa_pkg::OPC_LOAD: begin
				if (funct3 == 3'b010) begin
					decoded.op = isa_pkg::OP_LW;
					decoded.imm = imm_i;
				end
			end
			isa_pkg::OPC_STORE: begin
				if (funct3 == 3'b010) begin
					decoded.op = isa_pkg::OP_SW;
					decoded.imm = imm_s;
				end
			end
			isa_pkg::OPC_OP_IMM: begin
				if (funct3 == 3'b000) begin
					decoded.op = isa_pkg::OP_ADDI;
					decoded.imm = imm_i;
				end
			end
			isa_pkg::OPC_OP: begin
				if (funct3 == 3'b000 && inst[31:25] == 7'b0)
					decoded.op = isa_pkg::OP_ADD;
			end
			default: ;
		endcase
		decoded.reg_write = (decoded.rd != '0) && (decoded.op inside {isa_pkg::OP_LUI,
			isa_pkg::OP_AUIPC, isa_pkg::OP_JAL, isa_pkg::OP_JALR, isa_pkg::OP_LW,
			isa_pkg::OP_ADDI, isa_pkg::OP_ADD});
		decoded.is_mem = decoded.op inside {isa_pkg::OP_LW, isa_pkg::OP_SW};
	end

endmodule

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps

module fetch_unit #(
	parameter logic [31:0] RESET_PC = 32'h3000_0000
) (
	input  logic              clock,
	input  logic              rst_n,
	input  logic [31:0]       next_pc,
	input  isa_pkg::decoded_t decoded,
	input  logic              mem_done,
	output axi_pkg::ar_t      fetch_ar,
	output logic              fetch_ar_valid,
	input  logic              fetch_ar_ready,
	input  axi_pkg::r_t       fetch_r,
	input  logic              fetch_r_valid,
	output logic              fetch_r_ready,
	output logic [31:0]       inst,
	output logic              inst_valid,
	output logic              retire,
	output logic [31:0]       pc
);

	typedef enum logic [2:0] {
		S_FETCH,
		S_WAIT_R,
		S_EXEC,
		S_WAIT_MEM,
		S_RETIRE
	} state_e;

	state_e state;

	assign fetch_ar = '{addr: pc, id: axi_pkg::ID_FETCH, size: axi_pkg::SIZE_WORD};
	assign fetch_r_ready = (state == S_WAIT_R);
	assign inst_valid = (state == S_EXEC); // decoder output is settled from here on
	assign retire = (state == S_RETIRE);

	always_ff @(posedge clock) begin
		if (!rst_n) begin
			state <= S_FETCH;
			fetch_ar_valid <= 1'b0;
			pc <= RESET_PC;
		end else begin
			case (state)
				S_FETCH: begin
					if (fetch_ar_valid && fetch_ar_ready) begin
						fetch_ar_valid <= 1'b0;
						state <= S_WAIT_R;
					end else begin
						fetch_ar_valid <= 1'b1; // only changes anything right after reset
					end
				end
				S_WAIT_R: begin
					if (fetch_r_valid)
						state <= S_EXEC;
				end
				S_EXEC: state <= decoded.is_mem ? S_WAIT_MEM : S_RETIRE;
				S_WAIT_MEM: begin
					if (mem_done)
						state <= S_RETIRE;
				end
				S_RETIRE: begin
					pc <= next_pc;
					fetch_ar_valid <= 1'b1; // next request goes out with the new pc
					state <= S_FETCH;
				end
				default: state <= S_FETCH;
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (fetch_r_valid && fetch_r_ready)
			inst <= fetch_r.data;
	end

	a_fetch_ar_stable: assert property (@(posedge clock) disable iff (!rst_n)
		fetch_ar_valid && !fetch_ar_ready |=> fetch_ar_valid && $stable(fetch_ar));

endmodule

// ==== src/axi_pkg.sv ====
package axi_pkg;

	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int ID_W   = 4;

	localparam logic [ID_W-1:0] ID_FETCH = 4'd0;
	localparam logic [ID_W-1:0] ID_LSU   = 4'd1;

	localparam logic [2:0] SIZE_WORD = 3'b010; // 4 bytes per beat

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [ID_W-1:0]   id;
		logic [2:0]        size;
	} ar_t;

	typedef struct packed {
		logic [ADDR_W-1:0] addr;
		logic [2:0]        size;
	} aw_t;

	typedef struct packed {
		logic [DATA_W-1:0]   data;
		logic [DATA_W/8-1:0] strb;
	} w_t;

	typedef struct packed {
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic [ID_W-1:0]   id;
	} r_t;

	typedef struct packed {
		logic [1:0] resp;
	} b_t;

endpackage

// ==== src/isa_pkg.sv ====
package isa_pkg;

	localparam int XLEN      = 32;
	localparam int REG_IDX_W = 4;
	localparam int OPC_W     = 7;

	// major opcodes of the supported subset
	localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
	localparam logic [OPC_W-1:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [OPC_W-1:0] OPC_JAL    = 7'b1101111;
	localparam logic [OPC_W-1:0] OPC_JALR   = 7'b1100111;
	localparam logic [OPC_W-1:0] OPC_BRANCH = 7'b1100011;
	localparam logic [OPC_W-1:0] OPC_LOAD   = 7'b0000011;
	localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;
	localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;

	typedef logic [REG_IDX_W-1:0] reg_idx_t;

	typedef enum logic [3:0] {
		OP_LUI,
		OP_AUIPC,
		OP_JAL,
		OP_JALR,
		OP_BEQ,
		OP_LW,
		OP_SW,
		OP_ADDI,
		OP_ADD,
		OP_NOP // anything not recognized retires without effect
	} op_e;

	typedef struct packed {
		op_e             op;
		reg_idx_t        rd;
		reg_idx_t        rs1;
		reg_idx_t        rs2;
		logic [XLEN-1:0] imm;
		logic            reg_write;
		logic            is_mem;
	} decoded_t;

endpackage
